/* src/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int NUM_SETS  = 256;
    localparam int NUM_BANKS = 4;   // 32-bit banks per line
    localparam int INDEX_W   = 8;
    localparam int TAG_W     = 20;
    localparam int OFFSET_W  = 4;

    localparam logic [7:0] LFSR_SEED = 8'h01;  // victim lfsr reset value

    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [1:0]          bank_t;    // offset[3:2]
    typedef logic [31:0]         word_t;
    typedef logic [3:0]          strb_t;    // one bit per byte
    typedef logic [NUM_BANKS*32-1:0] line_t;  // bank 0 in the low word
    typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] addr_t;

    // main cache controller
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } main_state_t;

    // store-hit write buffer
    typedef enum logic {
        WB_IDLE,
        WB_WRITE
    } wbuf_state_t;

endpackage

/* src/dcache_meta_way.sv */
`timescale 1ns/1ns

module dcache_meta_way (
    input  logic               clk,
    input  logic               resetn,
    input  dcache_pkg::index_t index,
    input  logic               tagv_wen,
    input  dcache_pkg::tag_t   tag_wdata,
    input  logic               d_wen,
    input  logic               d_wdata,
    input  dcache_pkg::index_t d_index,
    output dcache_pkg::tag_t   tag,
    output logic               v,
    output logic               d
);

    dcache_pkg::tag_t                tag_mem [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0] v_bits;
    logic [dcache_pkg::NUM_SETS-1:0] d_bits;

    // tag ram, read before write
    always_ff @(posedge clk) begin
        if (tagv_wen) begin
            tag_mem[index] <= tag_wdata;
        end
        tag <= tag_mem[index];
    end

    // valid bits, registered alongside the tag
    always_ff @(posedge clk) begin
        if (!resetn) begin
            v_bits <= '0;
            v      <= 1'b0;
        end else begin
            if (tagv_wen) begin
                v_bits[index] <= 1'b1;  // refill makes the line valid
            end
            v <= v_bits[index];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            d_bits <= '0;
        end else if (d_wen) begin
            d_bits[d_index] <= d_wdata;
        end
    end

    assign d = d_bits[d_index];  // no register, victim check needs it now

endmodule

/* src/dcache_data_way.sv */
`timescale 1ns/1ns

module dcache_data_way (
    input  logic                                          clk,
    input  dcache_pkg::index_t [dcache_pkg::NUM_BANKS-1:0] bank_index,
    input  dcache_pkg::strb_t  [dcache_pkg::NUM_BANKS-1:0] bank_wen,
    input  dcache_pkg::word_t                             wdata,
    output dcache_pkg::line_t                             rdata
);

    for (genvar b = 0; b < dcache_pkg::NUM_BANKS; b++) begin : g_bank
        dcache_pkg::word_t mem [dcache_pkg::NUM_SETS];
        dcache_pkg::word_t fwd_word;
        dcache_pkg::word_t rd_word;

        // stored word with this cycle's bytes merged in
        always_comb begin
            fwd_word = mem[bank_index[b]];
            for (int i = 0; i < 4; i++) begin
                if (bank_wen[b][i]) begin
                    fwd_word[8*i +: 8] = wdata[8*i +: 8];
                end
            end
        end

        always_ff @(posedge clk) begin
            for (int i = 0; i < 4; i++) begin
                if (bank_wen[b][i]) begin
                    mem[bank_index[b]][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rd_word <= fwd_word;  // write-first
        end

        assign rdata[32*b +: 32] = rd_word;
    end

endmodule

/* src/dcache_lookup.sv */
`timescale 1ns/1ns

module dcache_lookup (
    input  dcache_pkg::tag_t  req_tag,
    input  dcache_pkg::bank_t req_bank,
    input  logic              victim_way,
    input  dcache_pkg::tag_t  way0_tag,
    input  dcache_pkg::tag_t  way1_tag,
    input  logic              way0_v,
    input  logic              way1_v,
    input  logic              way0_d,
    input  logic              way1_d,
    input  dcache_pkg::line_t way0_line,
    input  dcache_pkg::line_t way1_line,
    output logic              way0_hit,
    output logic              way1_hit,
    output logic              hit,
    output dcache_pkg::word_t hit_word,
    output dcache_pkg::line_t victim_line,
    output dcache_pkg::tag_t  victim_tag,
    output logic              victim_dirty
);

    dcache_pkg::word_t way0_word;
    dcache_pkg::word_t way1_word;

    // tag compare against the buffered request
    assign way0_hit = way0_v && (way0_tag == req_tag);
    assign way1_hit = way1_v && (way1_tag == req_tag);
    assign hit      = way0_hit || way1_hit;

    assign way0_word = way0_line[32*req_bank +: 32];
    assign way1_word = way1_line[32*req_bank +: 32];
    assign hit_word  = way1_hit ? way1_word : way0_word;  // only used on a hit

    // victim select
    assign victim_line = victim_way ? way1_line : way0_line;
    assign victim_tag  = victim_way ? way1_tag : way0_tag;

    // an invalid line never needs write-back, whatever its dirty bit says
    assign victim_dirty = victim_way ? (way1_v && way1_d) : (way0_v && way0_d);

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                clk,
    input  logic                resetn,
    // cpu
    input  logic                valid,
    input  logic                op,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::tag_t    tag,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::strb_t   wstrb,
    input  dcache_pkg::word_t   wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,
    // memory
    output logic                rd_req,
    output dcache_pkg::addr_t   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  dcache_pkg::word_t   ret_data,
    output logic                wr_req,
    output dcache_pkg::addr_t   wr_addr,
    output dcache_pkg::line_t   wr_data,
    input  logic                wr_rdy,
    // from lookup
    input  logic                way0_hit,
    input  logic                way1_hit,
    input  logic                hit,
    input  dcache_pkg::word_t   hit_word,
    input  dcache_pkg::line_t   victim_line,
    input  dcache_pkg::tag_t    victim_tag,
    input  logic                victim_dirty,
    // to lookup
    output dcache_pkg::tag_t    req_tag,
    output dcache_pkg::bank_t   req_bank,
    output logic                victim_way,
    // arrays
    output dcache_pkg::index_t  meta_index,
    output logic                way0_tagv_wen,
    output logic                way1_tagv_wen,
    output logic                way0_d_wen,
    output logic                way1_d_wen,
    output logic                d_wdata,
    output dcache_pkg::index_t  d_index,
    output dcache_pkg::index_t [dcache_pkg::NUM_BANKS-1:0] way0_bank_index,
    output dcache_pkg::index_t [dcache_pkg::NUM_BANKS-1:0] way1_bank_index,
    output dcache_pkg::strb_t  [dcache_pkg::NUM_BANKS-1:0] way0_bank_wen,
    output dcache_pkg::strb_t  [dcache_pkg::NUM_BANKS-1:0] way1_bank_wen,
    output dcache_pkg::word_t   bank_wdata
);

    dcache_pkg::main_state_t main_state;
    dcache_pkg::main_state_t main_next;
    dcache_pkg::wbuf_state_t wbuf_state;
    dcache_pkg::wbuf_state_t wbuf_next;

    // request buffer
    logic               req_op;
    dcache_pkg::index_t req_index;
    dcache_pkg::strb_t  req_wstrb;
    dcache_pkg::word_t  req_wdata;

    // write buffer
    dcache_pkg::index_t w_index;
    logic               w_way;
    dcache_pkg::bank_t  w_bank;
    dcache_pkg::strb_t  w_wstrb;
    dcache_pkg::word_t  w_wdata;

    dcache_pkg::bank_t  refill_cnt;
    logic [7:0]         lfsr;
    logic               first_replace;

    dcache_pkg::bank_t  cpu_bank;
    dcache_pkg::index_t rd_index;
    dcache_pkg::word_t  store_mask;
    dcache_pkg::word_t  refill_word;
    logic               in_lookup;
    logic               wb_write;
    logic               conflict;
    logic               accept;
    logic               store_hit;
    logic               refill_beat;
    logic               refill_done;
    logic               req_beat;

    assign cpu_bank  = offset[3:2];
    assign in_lookup = main_state == dcache_pkg::LOOKUP;
    assign wb_write  = wbuf_state == dcache_pkg::WB_WRITE;

    // a read may not pass a pending store to the same bank
    assign conflict = !op
        && ((in_lookup && req_op && {tag, index, cpu_bank} == {req_tag, req_index, req_bank})
            || (wb_write && cpu_bank == w_bank));

    assign addr_ok   = (main_state == dcache_pkg::IDLE || (in_lookup && hit)) && !conflict;
    assign accept    = valid && addr_ok;
    assign store_hit = in_lookup && req_op && hit;

    assign refill_beat = main_state == dcache_pkg::REFILL && ret_valid;
    assign refill_done = refill_beat && ret_last;
    assign req_beat    = refill_beat && refill_cnt == req_bank;

    assign data_ok = (in_lookup && (hit || req_op)) || (req_beat && !req_op);
    assign rdata   = in_lookup ? hit_word : ret_data;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            main_state <= dcache_pkg::IDLE;
            wbuf_state <= dcache_pkg::WB_IDLE;
        end else begin
            main_state <= main_next;
            wbuf_state <= wbuf_next;
        end
    end

    always_comb begin
        main_next = main_state;
        case (main_state)
            dcache_pkg::IDLE: begin
                if (accept) begin
                    main_next = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (!hit) begin
                    main_next = dcache_pkg::MISS;
                end else if (!accept) begin
                    main_next = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::MISS: begin
                if (wr_rdy) begin
                    main_next = dcache_pkg::REPLACE;
                end
            end
            dcache_pkg::REPLACE: begin
                if (rd_rdy) begin
                    main_next = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (refill_done) begin
                    main_next = dcache_pkg::IDLE;
                end
            end
            default: main_next = dcache_pkg::IDLE;
        endcase
    end

    // one store per cycle at most, so the buffer never holds two
    assign wbuf_next = store_hit ? dcache_pkg::WB_WRITE : dcache_pkg::WB_IDLE;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= cpu_bank;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            w_index <= req_index;
            w_way   <= {way1_hit, way0_hit} == 2'b10;
            w_bank  <= req_bank;
            w_wstrb <= req_wstrb;
            w_wdata <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            refill_cnt <= '0;
        end else if (refill_beat) begin
            refill_cnt <= ret_last ? 2'd0 : refill_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= dcache_pkg::LFSR_SEED;
        end else if (refill_done) begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign victim_way = lfsr[0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            first_replace <= 1'b0;
        end else begin
            first_replace <= main_state == dcache_pkg::MISS && main_next == dcache_pkg::REPLACE;
        end
    end

    // memory side, whole lines only
    assign rd_req  = main_state == dcache_pkg::REPLACE;
    assign rd_addr = {req_tag, req_index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign wr_req  = first_replace && victim_dirty;
    assign wr_addr = {victim_tag, req_index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign wr_data = victim_line;

    assign rd_index   = (main_state == dcache_pkg::IDLE || in_lookup) ? index : req_index;
    assign meta_index = rd_index;

    assign way0_tagv_wen = refill_done && !victim_way;
    assign way1_tagv_wen = refill_done && victim_way;

    // store hit sets dirty, refill leaves it dirty only for a write miss
    assign d_index    = wb_write ? w_index : req_index;
    assign d_wdata    = wb_write || req_op;
    assign way0_d_wen = (wb_write && !w_way) || (refill_done && !victim_way);
    assign way1_d_wen = (wb_write && w_way) || (refill_done && victim_way);

    assign store_mask = {{8{req_wstrb[3]}}, {8{req_wstrb[2]}}, {8{req_wstrb[1]}}, {8{req_wstrb[0]}}};
    assign refill_word = (req_op && refill_cnt == req_bank)
        ? ((req_wdata & store_mask) | (ret_data & ~store_mask))  // write miss merge
        : ret_data;
    assign bank_wdata = wb_write ? w_wdata : refill_word;

    always_comb begin
        for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
            way0_bank_index[b] = rd_index;
            way1_bank_index[b] = rd_index;
            way0_bank_wen[b]   = '0;
            way1_bank_wen[b]   = '0;
            if (wb_write && w_bank == b) begin
                if (w_way) begin
                    way1_bank_index[b] = w_index;
                    way1_bank_wen[b]   = w_wstrb;
                end else begin
                    way0_bank_index[b] = w_index;
                    way0_bank_wen[b]   = w_wstrb;
                end
            end else if (refill_beat && refill_cnt == b) begin
                if (victim_way) begin
                    way1_bank_wen[b] = '1;
                end else begin
                    way0_bank_wen[b] = '1;
                end
            end
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top (
    input  logic                clk,
    input  logic                resetn,
    // cpu
    input  logic                valid,
    input  logic                op,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::tag_t    tag,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::strb_t   wstrb,
    input  dcache_pkg::word_t   wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,
    // memory
    output logic                rd_req,
    output dcache_pkg::addr_t   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  dcache_pkg::word_t   ret_data,
    output logic                wr_req,
    output dcache_pkg::addr_t   wr_addr,
    output dcache_pkg::line_t   wr_data,
    input  logic                wr_rdy
);

    dcache_pkg::tag_t   req_tag;
    dcache_pkg::bank_t  req_bank;
    logic               victim_way;
    logic               way0_hit;
    logic               way1_hit;
    logic               hit;
    dcache_pkg::word_t  hit_word;
    dcache_pkg::line_t  victim_line;
    dcache_pkg::tag_t   victim_tag;
    logic               victim_dirty;

    dcache_pkg::index_t meta_index;
    dcache_pkg::index_t d_index;
    logic               way0_tagv_wen;
    logic               way1_tagv_wen;
    logic               way0_d_wen;
    logic               way1_d_wen;
    logic               d_wdata;
    dcache_pkg::index_t [dcache_pkg::NUM_BANKS-1:0] way0_bank_index;
    dcache_pkg::index_t [dcache_pkg::NUM_BANKS-1:0] way1_bank_index;
    dcache_pkg::strb_t  [dcache_pkg::NUM_BANKS-1:0] way0_bank_wen;
    dcache_pkg::strb_t  [dcache_pkg::NUM_BANKS-1:0] way1_bank_wen;
    dcache_pkg::word_t  bank_wdata;

    dcache_pkg::tag_t   way0_tag;
    dcache_pkg::tag_t   way1_tag;
    logic               way0_v;
    logic               way1_v;
    logic               way0_d;
    logic               way1_d;
    dcache_pkg::line_t  way0_line;
    dcache_pkg::line_t  way1_line;

    dcache_ctrl ctrl_i (.*);

    dcache_lookup lookup_i (.*);

    dcache_meta_way meta_way0_i (
        .clk       (clk),
        .resetn    (resetn),
        .index     (meta_index),
        .tagv_wen  (way0_tagv_wen),
        .tag_wdata (req_tag),       // refill tag comes from the request buffer
        .d_wen     (way0_d_wen),
        .d_wdata   (d_wdata),
        .d_index   (d_index),
        .tag       (way0_tag),
        .v         (way0_v),
        .d         (way0_d)
    );

    dcache_meta_way meta_way1_i (
        .clk       (clk),
        .resetn    (resetn),
        .index     (meta_index),
        .tagv_wen  (way1_tagv_wen),
        .tag_wdata (req_tag),
        .d_wen     (way1_d_wen),
        .d_wdata   (d_wdata),
        .d_index   (d_index),
        .tag       (way1_tag),
        .v         (way1_v),
        .d         (way1_d)
    );

    dcache_data_way data_way0_i (
        .clk        (clk),
        .bank_index (way0_bank_index),
        .bank_wen   (way0_bank_wen),
        .wdata      (bank_wdata),
        .rdata      (way0_line)
    );

    dcache_data_way data_way1_i (
        .clk        (clk),
        .bank_index (way1_bank_index),
        .bank_wen   (way1_bank_wen),
        .wdata      (bank_wdata),
        .rdata      (way1_line)
    );

endmodule

/* test/dcache_mem_model.sv */
`timescale 1ns/1ns

module dcache_mem_model (
    input  logic              clk,
    input  logic              resetn,
    input  logic              rd_req,
    input  dcache_pkg::addr_t rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output logic              ret_last,
    output dcache_pkg::word_t ret_data,
    input  logic              wr_req,
    input  dcache_pkg::addr_t wr_addr,
    input  dcache_pkg::line_t wr_data,
    output logic              wr_rdy
);

    dcache_pkg::word_t mem [dcache_pkg::addr_t];  // only words written back
    dcache_pkg::addr_t line_addr;

    // untouched words start as a mix of every address bit
    function automatic dcache_pkg::word_t init_word(input dcache_pkg::addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);
    endfunction

    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return init_word(a);
    endfunction

    // write-back capture
    always @(posedge clk) begin
        if (resetn && wr_req) begin
            for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
                mem[wr_addr + 4 * b] = wr_data[32*b +: 32];
            end
        end
    end

    initial begin
        wr_rdy = 1'b0;
        forever begin
            @(negedge clk);
            wr_rdy = ($urandom_range(0, 3) != 0);  // occasional back-pressure
        end
    end

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (resetn && rd_req) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                rd_rdy    = 1'b1;
                line_addr = rd_addr;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
                    repeat ($urandom_range(0, 1)) @(negedge clk);  // gap between beats
                    ret_valid = 1'b1;
                    ret_data  = read_word(line_addr + 4 * b);
                    ret_last  = (b == dcache_pkg::NUM_BANKS - 1);
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

endmodule

/* test/dcache_sva.sv */
`timescale 1ns/1ns

module dcache_sva (
    input logic                    clk,
    input logic                    resetn,
    input logic                    wr_req,
    input logic                    data_ok,
    input logic                    rd_req,
    input logic                    rd_rdy,
    input dcache_pkg::main_state_t main_state
);

    wr_req_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |=> !wr_req)
        else $error("wr_req held longer than one cycle");

    no_data_ok_in_idle: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> main_state != dcache_pkg::IDLE)
        else $error("data_ok raised in IDLE");

    // line read request holds until memory takes it
    rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    legal_state: assert property (@(posedge clk) disable iff (!resetn)
        main_state inside {dcache_pkg::IDLE, dcache_pkg::LOOKUP, dcache_pkg::MISS,
                           dcache_pkg::REPLACE, dcache_pkg::REFILL})
        else $error("main state left its legal encodings");

endmodule

bind dcache_ctrl dcache_sva sva_i (
    .clk        (clk),
    .resetn     (resetn),
    .wr_req     (wr_req),
    .data_ok    (data_ok),
    .rd_req     (rd_req),
    .rd_rdy     (rd_rdy),
    .main_state (main_state)
);

/* test/dcache_tb.sv */
`timescale 1ns/1ns

module dcache_tb;

    logic                clk = 1'b0;
    logic                resetn;
    logic                valid;
    logic                op;
    dcache_pkg::index_t  index;
    dcache_pkg::tag_t    tag;
    dcache_pkg::offset_t offset;
    dcache_pkg::strb_t   wstrb;
    dcache_pkg::word_t   wdata;
    logic                addr_ok;
    logic                data_ok;
    dcache_pkg::word_t   rdata;
    logic                rd_req;
    dcache_pkg::addr_t   rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    logic                ret_last;
    dcache_pkg::word_t   ret_data;
    logic                wr_req;
    dcache_pkg::addr_t   wr_addr;
    dcache_pkg::line_t   wr_data;
    logic                wr_rdy;

    string               test_name;
    dcache_pkg::word_t   shadow [dcache_pkg::addr_t];  // cpu view, written words only
    logic                q_op [$];
    dcache_pkg::addr_t   q_addr [$];
    dcache_pkg::strb_t   q_strb [$];
    dcache_pkg::word_t   q_data [$];

    dcache_top dcache_top_i (.*);
    dcache_mem_model mem_i (.*);

    always #50 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // same start pattern as main memory holds before any write-back
    function automatic dcache_pkg::word_t initial_word(input dcache_pkg::addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);
    endfunction

    function automatic dcache_pkg::word_t shadow_word(input dcache_pkg::addr_t a);
        dcache_pkg::addr_t w;
        w = {a[31:2], 2'b00};
        if (shadow.exists(w)) begin
            return shadow[w];
        end
        return initial_word(w);
    endfunction

    task automatic push_req(input logic w, input dcache_pkg::addr_t a, input dcache_pkg::strb_t s);
        q_op.push_back(w);
        q_addr.push_back(a);
        q_strb.push_back(s);
        q_data.push_back($urandom);
    endtask

    // issues queued requests back to back, responses come back in order
    task automatic run_requests(input bit no_refill);
        int                sent;
        int                got;
        int                idle_cycles;
        dcache_pkg::addr_t a;
        dcache_pkg::addr_t miss_addr;
        dcache_pkg::word_t mask;
        sent = 0;
        got = 0;
        idle_cycles = 0;
        while (got < q_op.size()) begin
            @(negedge clk);
            if (sent < q_op.size()) begin
                a      = q_addr[sent];
                valid  = 1'b1;
                op     = q_op[sent];
                tag    = a[31:12];
                index  = a[11:4];
                offset = a[3:0];
                wstrb  = q_strb[sent];
                wdata  = q_data[sent];
            end else begin
                valid = 1'b0;
            end
            #1;
            if (no_refill && rd_req) begin
                fail_run($sformatf("%s: line read issued for a cached access", test_name));
            end
            if (rd_req && sent > 0) begin
                miss_addr = q_addr[sent - 1];  // a miss accepts nothing behind it
                check_value($sformatf("%s line read address", test_name),
                            {miss_addr[31:4], 4'h0}, rd_addr);
            end
            if (data_ok) begin
                if (got >= sent) begin
                    fail_run($sformatf("%s: data_ok with no request outstanding", test_name));
                end
                if (!q_op[got]) begin
                    check_value(test_name, shadow_word(q_addr[got]), rdata);
                end
                got++;
                idle_cycles = 0;
            end
            if (valid && addr_ok) begin
                if (op) begin
                    mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
                    shadow[{a[31:2], 2'b00}] = (shadow_word(a) & ~mask) | (wdata & mask);
                end
                sent++;
                idle_cycles = 0;
            end
            idle_cycles++;
            if (idle_cycles > 300) begin
                fail_run($sformatf("%s: timed out waiting for the cache", test_name));
            end
        end
        q_op.delete();
        q_addr.delete();
        q_strb.delete();
        q_data.delete();
    endtask

    // every dirty victim leaving the cache must hold the cpu view
    always @(negedge clk) begin
        #1;
        if (resetn === 1'b1 && wr_req) begin
            check_value($sformatf("%s write-back address", test_name), 0, wr_addr[3:0]);
            for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
                check_value($sformatf("%s write-back", test_name),
                            shadow_word(wr_addr + 4 * b), wr_data[32*b +: 32]);
            end
        end
    end

    task automatic after_reset_outputs();
        test_name = "reset";
        @(negedge clk);
        #1;
        check_value(test_name, 1, addr_ok);
        check_value(test_name, 0, data_ok);
        check_value(test_name, 0, rd_req);
        check_value(test_name, 0, wr_req);
    endtask

    task automatic read_miss_then_hits();
        test_name = "read miss then hits";
        push_req(1'b0, 32'h0001_2344, 4'h0);
        run_requests(1'b0);
        for (int i = 0; i < 4; i++) begin
            push_req(1'b0, 32'h0001_2340 + 4 * i, 4'h0);
        end
        run_requests(1'b1);
    endtask

    task automatic write_hit_merge();
        test_name = "write hit";
        push_req(1'b1, 32'h0001_2348, 4'b0101);
        push_req(1'b0, 32'h0001_2348, 4'h0);  // same bank right behind the store
        push_req(1'b0, 32'h0001_234c, 4'h0);
        push_req(1'b1, 32'h0001_2344, 4'b1000);
        push_req(1'b0, 32'h0001_2340, 4'h0);
        push_req(1'b0, 32'h0001_2344, 4'h0);
        run_requests(1'b1);
    endtask

    task automatic write_miss_refill();
        test_name = "write miss";
        push_req(1'b1, 32'h0045_6784, 4'b0110);
        for (int i = 0; i < 4; i++) begin
            push_req(1'b0, 32'h0045_6780 + 4 * i, 4'h0);
        end
        run_requests(1'b0);
    endtask

    task automatic set_eviction();
        dcache_pkg::addr_t a;
        test_name = "eviction";
        for (int round = 0; round < 3; round++) begin
            for (int t = 0; t < 3; t++) begin
                a = {20'h0a000 + 20'(t), 8'h9a, 4'h0};
                push_req(1'b1, a + 4 * ((t + round) % 4), 4'b1111);
            end
            for (int t = 0; t < 3; t++) begin
                a = {20'h0a000 + 20'(t), 8'h9a, 4'h0};
                push_req(1'b0, a + 4 * ((t + round) % 4), 4'h0);
                push_req(1'b0, a + 4 * ((t + round + 1) % 4), 4'h0);
            end
            run_requests(1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'hf8d7_2f6a));
        resetn = 1'b0;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        after_reset_outputs();
        read_miss_then_hits();
        write_hit_merge();
        write_miss_refill();
        set_eviction();
        repeat (2) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* dcache.f */
src/dcache_pkg.sv
src/dcache_meta_way.sv
src/dcache_data_way.sv
src/dcache_lookup.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_sva.sv
test/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache_top
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)
